//--- logic/scope_pkg.sv
package scope_pkg;

    // Number of sample streams merged by the combiner
    localparam int N_CHANNELS = 4;

    // Width of the trigger output vector
    localparam int N_TRIGGERS = 4;

    // Capture FIFO depth must stay a power of two so the pointers wrap on their own
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // One ADC sample as delivered by a channel
    typedef logic [15:0] sample_t;

    // Index of an input channel, used as the tag of a combined word
    typedef logic [1:0] channel_id_t;

    // Combined word layout
    //   31:24  channel id, zero extended
    //   23:16  zero
    //   15:0   sample
    typedef logic [31:0] scope_word_t;

    // Frame length and the position of a word inside its frame
    typedef logic [15:0] frame_count_t;

endpackage

//--- logic/scope_regs_pkg.sv
package scope_regs_pkg;

    // Software register port
    typedef logic [2:0]  reg_address_t;
    typedef logic [31:0] reg_data_t;

    // Configuration registers
    localparam reg_address_t ADDR_FRAME_LENGTH     = 3'd0;
    localparam reg_address_t ADDR_TRIGGER_SELECT   = 3'd1;
    localparam reg_address_t ADDR_TRIGGER_POSITION = 3'd2;

    // A write here arms the trigger hub and the address always reads zero
    localparam reg_address_t ADDR_SOFT_TRIGGER     = 3'd3;

    // A write here releases a held capture and a read returns the inhibit flag in bit 0
    localparam reg_address_t ADDR_CAPTURE_ACK      = 3'd4;

    // Addresses 5 to 7 are unmapped and read as zero

    // Values loaded into the configuration registers on reset
    localparam logic [15:0] FRAME_LENGTH_RESET     = 16'd8;
    localparam logic [1:0]  TRIGGER_SELECT_RESET   = 2'd0;
    localparam logic [15:0] TRIGGER_POSITION_RESET = 16'd0;

endpackage

//--- logic/scope_registers.sv
`timescale 1ns/1ps

module scope_registers
    import scope_pkg::*;
    import scope_regs_pkg::*;
(
    input  logic         clock,
    input  logic         arst_n,
    input  logic         reg_write,
    input  reg_address_t reg_address,
    input  reg_data_t    reg_write_data,
    output reg_data_t    reg_read_data,
    input  logic         capture_inhibit,
    output frame_count_t frame_length,
    output logic [1:0]   trigger_select,
    output frame_count_t trigger_position,
    output logic         soft_trigger,
    output logic         capture_ack
);

    // Configuration registers, updated by software writes
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame_length     <= FRAME_LENGTH_RESET;
            trigger_select   <= TRIGGER_SELECT_RESET;
            trigger_position <= TRIGGER_POSITION_RESET;
        end else if (reg_write) begin
            case (reg_address)
                ADDR_FRAME_LENGTH: begin
                    frame_length <= reg_write_data[15:0];
                end
                ADDR_TRIGGER_SELECT: begin
                    trigger_select <= reg_write_data[1:0];
                end
                ADDR_TRIGGER_POSITION: begin
                    trigger_position <= reg_write_data[15:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Command strobes are single-cycle pulses issued the cycle after the write.
    // The written data is ignored, only the address matters
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            soft_trigger <= 1'b0;
            capture_ack  <= 1'b0;
        end else begin
            soft_trigger <= reg_write && (reg_address == ADDR_SOFT_TRIGGER);
            capture_ack  <= reg_write && (reg_address == ADDR_CAPTURE_ACK);
        end
    end

    // Readback is purely combinational from the address
    always_comb begin
        case (reg_address)
            ADDR_FRAME_LENGTH:     reg_read_data = {16'h0000, frame_length};
            ADDR_TRIGGER_SELECT:   reg_read_data = {30'd0, trigger_select};
            ADDR_TRIGGER_POSITION: reg_read_data = {16'h0000, trigger_position};
            ADDR_CAPTURE_ACK:      reg_read_data = {31'd0, capture_inhibit};
            default:               reg_read_data = '0;
        endcase
    end

endmodule

//--- logic/channel_combiner.sv
`timescale 1ns/1ps

module channel_combiner
    import scope_pkg::*;
(
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [N_CHANNELS-1:0]    ch_valid,
    input  sample_t [N_CHANNELS-1:0] ch_sample,
    output logic [N_CHANNELS-1:0]    ch_ready,
    output logic                     comb_valid,
    output scope_word_t              comb_word,
    input  logic                     comb_ready
);

    channel_id_t rr_pointer;
    channel_id_t grant_id;
    logic        grant_found;
    logic        load;

    // The output register takes a new word when it is empty or drained this cycle
    assign load = !comb_valid || comb_ready;

    // Pick the first valid channel at or after the round-robin pointer.
    // The index wraps through the channel id width
    always_comb begin
        grant_found = 1'b0;
        grant_id    = rr_pointer;
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (!grant_found && ch_valid[channel_id_t'(rr_pointer + i)]) begin
                grant_found = 1'b1;
                grant_id    = channel_id_t'(rr_pointer + i);
            end
        end
    end

    // Only the granted channel sees ready, and only while the register can load
    always_comb begin
        ch_ready = '0;
        if (load && grant_found) begin
            ch_ready[grant_id] = 1'b1;
        end
    end

    // Valid flag and arbitration pointer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            comb_valid <= 1'b0;
            rr_pointer <= '0;
        end else if (load) begin
            comb_valid <= grant_found;
            if (grant_found) begin
                // Skip past the winner so every channel gets its turn
                rr_pointer <= grant_id + 2'd1;
            end
        end
    end

    // Tagged word register
    always_ff @(posedge clock) begin
        if (load && grant_found) begin
            comb_word <= {6'd0, grant_id, 8'h00, ch_sample[grant_id]};
        end
    end

endmodule

//--- logic/trigger_hub.sv
`timescale 1ns/1ps

module trigger_hub
    import scope_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  soft_trigger,
    input  logic                  capture_ack,
    input  logic [1:0]            trigger_select,
    input  frame_count_t          trigger_position,
    input  frame_count_t          frame_position,
    input  logic                  word_taken,
    input  logic                  frame_end,
    output logic                  capture_inhibit,
    output logic [N_TRIGGERS-1:0] trigger_out
);

    typedef enum logic [1:0] {
        HUB_IDLE,
        HUB_ARMED,
        HUB_FIRED,
        HUB_HELD
    } hub_state_t;

    hub_state_t            state;
    logic                  position_hit;
    logic [N_TRIGGERS-1:0] select_onehot;

    // A word at the programmed position is passing into the FIFO
    assign position_hit = word_taken && (frame_position == trigger_position);

    // Capture stays blocked for as long as the hub holds
    assign capture_inhibit = (state == HUB_HELD);

    always_comb begin
        select_onehot = '0;
        select_onehot[trigger_select] = 1'b1;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= HUB_IDLE;
            trigger_out <= '0;
        end else begin
            trigger_out <= '0;
            case (state)
                HUB_IDLE: begin
                    if (soft_trigger) begin
                        state <= HUB_ARMED;
                    end
                end
                HUB_ARMED: begin
                    if (position_hit) begin
                        trigger_out <= select_onehot;
                        // The trigger word can also be the last word of its frame
                        state <= frame_end ? HUB_HELD : HUB_FIRED;
                    end
                end
                HUB_FIRED: begin
                    if (frame_end) begin
                        state <= HUB_HELD;
                    end
                end
                HUB_HELD: begin
                    if (capture_ack) begin
                        state <= HUB_IDLE;
                    end
                end
                default: begin
                    state <= HUB_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/frame_marker.sv
`timescale 1ns/1ps

module frame_marker
    import scope_pkg::*;
(
    input  logic         clock,
    input  logic         arst_n,
    input  frame_count_t frame_length,
    input  logic         in_valid,
    input  scope_word_t  in_word,
    output logic         in_ready,
    output logic         out_valid,
    output scope_word_t  out_word,
    output logic         out_last,
    input  logic         out_ready,
    output frame_count_t frame_position
);

    frame_count_t word_count;
    frame_count_t last_position;

    assign last_position = frame_length - 16'd1;

    // Zero-latency pass-through of the stream itself
    assign out_valid = in_valid;
    assign out_word  = in_word;
    assign in_ready  = out_ready;

    // Greater-or-equal also ends a frame cleanly if the length shrinks mid-frame
    assign out_last = (word_count >= last_position);

    // Position of the word currently offered
    assign frame_position = word_count;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            word_count <= '0;
        end else if (in_valid && out_ready) begin
            if (out_last) begin
                word_count <= '0;
            end else begin
                word_count <= word_count + 16'd1;
            end
        end
    end

endmodule

//--- logic/capture_fifo.sv
`timescale 1ns/1ps

module capture_fifo
    import scope_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        in_valid,
    input  scope_word_t in_word,
    input  logic        in_last,
    output logic        in_ready,
    output logic        out_valid,
    output scope_word_t out_word,
    output logic        out_last,
    input  logic        out_ready
);

    typedef logic [FIFO_ADDR_W-1:0] index_t;
    typedef logic [FIFO_ADDR_W:0]   fill_t;

    scope_word_t word_mem [FIFO_DEPTH];
    logic        last_mem [FIFO_DEPTH];
    index_t      write_index;
    index_t      read_index;
    fill_t       fill_count;
    logic        push;
    logic        pop;

    assign in_ready  = (fill_count != fill_t'(FIFO_DEPTH));
    assign out_valid = (fill_count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // The head entry is read directly, so it stays put while the consumer stalls
    assign out_word = word_mem[read_index];
    assign out_last = last_mem[read_index];

    always_ff @(posedge clock) begin
        if (push) begin
            word_mem[write_index] <= in_word;
            last_mem[write_index] <= in_last;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            write_index <= '0;
            read_index  <= '0;
            fill_count  <= '0;
        end else begin
            if (push) begin
                write_index <= write_index + 1'b1;
            end
            if (pop) begin
                read_index <= read_index + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase
        end
    end

endmodule

//--- logic/scope_capture.sv
`timescale 1ns/1ps

module scope_capture
    import scope_pkg::*;
    import scope_regs_pkg::*;
(
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic [N_CHANNELS-1:0]    ch_valid,
    input  sample_t [N_CHANNELS-1:0] ch_sample,
    output logic [N_CHANNELS-1:0]    ch_ready,
    input  logic                     reg_write,
    input  reg_address_t             reg_address,
    input  reg_data_t                reg_write_data,
    output reg_data_t                reg_read_data,
    output logic                     out_valid,
    output scope_word_t              out_word,
    output logic                     out_last,
    input  logic                     out_ready,
    output logic [N_TRIGGERS-1:0]    trigger_out,
    output logic                     frame_done
);

    frame_count_t frame_length;
    logic [1:0]   trigger_select;
    frame_count_t trigger_position;
    frame_count_t frame_position;
    logic         soft_trigger;
    logic         capture_ack;
    logic         capture_inhibit;
    logic         comb_valid;
    scope_word_t  comb_word;
    logic         comb_ready;
    logic         gated_valid;
    logic         mark_valid;
    scope_word_t  mark_word;
    logic         mark_last;
    logic         mark_ready;
    logic         word_taken;
    logic         frame_end;

    scope_registers i_registers (
        .clock(clock), .arst_n(arst_n),
        .reg_write(reg_write), .reg_address(reg_address),
        .reg_write_data(reg_write_data), .reg_read_data(reg_read_data),
        .capture_inhibit(capture_inhibit), .frame_length(frame_length),
        .trigger_select(trigger_select), .trigger_position(trigger_position),
        .soft_trigger(soft_trigger), .capture_ack(capture_ack)
    );

    channel_combiner i_combiner (
        .clock(clock), .arst_n(arst_n),
        .ch_valid(ch_valid), .ch_sample(ch_sample), .ch_ready(ch_ready),
        .comb_valid(comb_valid), .comb_word(comb_word), .comb_ready(comb_ready)
    );

    // While inhibited the combiner keeps draining, so those words are dropped here
    assign gated_valid = comb_valid && !capture_inhibit;

    frame_marker i_marker (
        .clock(clock), .arst_n(arst_n), .frame_length(frame_length),
        .in_valid(gated_valid), .in_word(comb_word), .in_ready(comb_ready),
        .out_valid(mark_valid), .out_word(mark_word), .out_last(mark_last),
        .out_ready(mark_ready), .frame_position(frame_position)
    );

    assign word_taken = mark_valid && mark_ready;
    assign frame_end  = word_taken && mark_last;

    trigger_hub i_trigger_hub (
        .clock(clock), .arst_n(arst_n),
        .soft_trigger(soft_trigger), .capture_ack(capture_ack),
        .trigger_select(trigger_select), .trigger_position(trigger_position),
        .frame_position(frame_position), .word_taken(word_taken),
        .frame_end(frame_end), .capture_inhibit(capture_inhibit),
        .trigger_out(trigger_out)
    );

    capture_fifo i_fifo (
        .clock(clock), .arst_n(arst_n),
        .in_valid(mark_valid), .in_word(mark_word), .in_last(mark_last),
        .in_ready(mark_ready), .out_valid(out_valid), .out_word(out_word),
        .out_last(out_last), .out_ready(out_ready)
    );

    // Frame completion pulse for whatever moves the frame out of the FIFO
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_end;
        end
    end

endmodule

//--- test/scope_capture_asserts.sv
`timescale 1ns/1ps

module scope_capture_asserts
    import scope_pkg::*;
(
    input logic                  clock,
    input logic                  arst_n,
    input logic [N_TRIGGERS-1:0] trigger_out,
    input logic                  capture_inhibit,
    input logic                  capture_ack,
    input logic                  frame_end,
    input logic                  out_valid,
    input logic                  out_ready,
    input scope_word_t           out_word,
    input logic                  out_last,
    input logic                  frame_done
);

    // Only the selected trigger line may pulse
    trigger_onehot: assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(trigger_out)
    ) else $error("trigger_out has more than one bit set");

    // Capture is only blocked once a frame has ended
    inhibit_rise: assert property (
        @(posedge clock) disable iff (!arst_n)
        (!capture_inhibit && !frame_end) |=> !capture_inhibit
    ) else $error("capture inhibit raised without a frame end");

    // A held capture stays blocked until software acknowledges it
    inhibit_hold: assert property (
        @(posedge clock) disable iff (!arst_n)
        (capture_inhibit && !capture_ack) |=> capture_inhibit
    ) else $error("capture inhibit dropped without an acknowledge");

    output_stable: assert property (
        @(posedge clock) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word) && $stable(out_last))
    ) else $error("output stream changed while stalled");

    done_single: assert property (
        @(posedge clock) disable iff (!arst_n) frame_done |=> !frame_done
    ) else $error("frame_done high on two consecutive cycles");

endmodule

bind scope_capture scope_capture_asserts i_asserts (
    .clock(clock), .arst_n(arst_n), .trigger_out(trigger_out),
    .capture_inhibit(capture_inhibit), .capture_ack(capture_ack),
    .frame_end(frame_end),
    .out_valid(out_valid), .out_ready(out_ready), .out_word(out_word),
    .out_last(out_last), .frame_done(frame_done)
);

//--- test/scope_capture_tb.sv
`timescale 1ns/1ps

module scope_capture_tb
    import scope_pkg::*;
    import scope_regs_pkg::*;
();

    // Roughly 600 words at up to 8 cycles each, four times over, plus register traffic
    localparam int MAX_CYCLES = 600 * 8 * 4 + 800;

    logic                     clock;
    logic                     arst_n;
    logic [N_CHANNELS-1:0]    ch_valid;
    sample_t [N_CHANNELS-1:0] ch_sample;
    logic [N_CHANNELS-1:0]    ch_ready;
    logic                     reg_write;
    reg_address_t             reg_address;
    reg_data_t                reg_write_data;
    reg_data_t                reg_read_data;
    logic                     out_valid;
    scope_word_t              out_word;
    logic                     out_last;
    logic                     out_ready;
    logic [N_TRIGGERS-1:0]    trigger_out;
    logic                     frame_done;

    integer                seed;
    int                    cycle_count = 0;
    sample_t               expected_q [N_CHANNELS][$];
    frame_count_t          expected_length = 16'd8;
    frame_count_t          out_count = '0;
    channel_id_t           out_channel;
    sample_t               out_sample;
    logic                  held_valid = 1'b0;
    scope_word_t           held_word;
    logic                  held_last;
    int                    done_count = 0;
    int                    trigger_count = 0;
    int                    done_at_trigger = 0;
    logic [N_TRIGGERS-1:0] trigger_bits = '0;
    int                    done_before;
    int                    trigger_before;

    scope_capture i_dut (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // Channel id zero extended into the top byte, sample in the low half
    function automatic scope_word_t expected_word(channel_id_t id, sample_t sample);
        scope_word_t word;
        word        = '0;
        word[31:24] = 8'(id);
        word[15:0]  = sample;
        return word;
    endfunction

    function automatic int pending_samples();
        int total;
        total = 0;
        for (int c = 0; c < N_CHANNELS; c++) begin
            total += expected_q[c].size();
        end
        return total;
    endfunction

    task automatic report_failure();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(string name, scope_word_t actual, scope_word_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_reg(string name, reg_data_t actual, reg_data_t expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            report_failure();
        end
    endtask

    task automatic write_reg(reg_address_t address, reg_data_t data);
        @(posedge clock);
        reg_write      <= 1'b1;
        reg_address    <= address;
        reg_write_data <= data;
        @(posedge clock);
        reg_write <= 1'b0;
        if (address == ADDR_FRAME_LENGTH) begin
            expected_length = data[15:0];
        end
    endtask

    // Readback is combinational, so it is sampled mid-cycle
    task automatic expect_reg(reg_address_t address, reg_data_t expected, string name);
        @(posedge clock);
        reg_address <= address;
        @(negedge clock);
        check_reg(name, reg_read_data, expected);
    endtask

    // Offers total random samples spread over the channels until all are taken
    task automatic send_words(int total, logic captured, logic stall);
        int launched;
        int accepted;
        int stall_left;
        launched   = 0;
        accepted   = 0;
        stall_left = 0;
        while (accepted < total) begin
            @(posedge clock);
            for (int c = 0; c < N_CHANNELS; c++) begin
                if (ch_valid[c] && ch_ready[c]) begin
                    accepted++;
                    if (captured) begin
                        expected_q[c].push_back(ch_sample[c]);
                    end
                    ch_valid[c] <= 1'b0;
                end
                if ((!ch_valid[c] || ch_ready[c]) && launched < total
                        && $random(seed) % 2 == 0) begin
                    ch_valid[c]  <= 1'b1;
                    ch_sample[c] <= sample_t'($random(seed));
                    launched++;
                end
            end
            if (!stall) begin
                out_ready <= 1'b1;
            end else if (stall_left > 0) begin
                out_ready <= 1'b0;
                stall_left--;
            end else if ($random(seed) % 8 == 0) begin
                // A long low stretch fills the FIFO and pushes back to the channels
                out_ready  <= 1'b0;
                stall_left = 24 + int'($unsigned($random(seed)) % 16);
            end else begin
                out_ready <= ($random(seed) % 2 == 0);
            end
        end
    endtask

    task automatic wait_drained();
        @(posedge clock);
        out_ready <= 1'b1;
        do begin
            @(negedge clock);
        end while (pending_samples() != 0);
        // Give the monitor one more cycle to count a trailing frame_done
        @(negedge clock);
    endtask

    // Output compare against the per-channel queues
    always @(posedge clock) begin
        if (arst_n && held_valid) begin
            check_flag("out_valid", out_valid, 1'b1);
            check_word("out_word", out_word, held_word);
            check_flag("out_last", out_last, held_last);
        end
        held_valid = out_valid && !out_ready;
        held_word  = out_word;
        held_last  = out_last;
        if (arst_n && out_valid && out_ready) begin
            out_channel = out_word[25:24];
            if (expected_q[out_channel].size() == 0) begin
                $display("Error: a word for channel %0d came out with no sample pending",
                         out_channel);
                report_failure();
            end else begin
                out_sample = expected_q[out_channel].pop_front();
                check_word("out_word", out_word, expected_word(out_channel, out_sample));
                check_flag("out_last", out_last, out_count == expected_length - 16'd1);
                out_count = (out_count == expected_length - 16'd1) ? '0 : out_count + 16'd1;
            end
        end
    end

    always @(negedge clock) begin
        if (arst_n) begin
            if (frame_done) begin
                done_count++;
            end
            if (trigger_out != '0) begin
                trigger_count++;
                trigger_bits    = trigger_bits | trigger_out;
                done_at_trigger = done_count;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            report_failure();
        end
    end

    initial begin
        seed           = 81123;
        arst_n         = 1'b0;
        ch_valid       = '0;
        ch_sample      = '0;
        reg_write      = 1'b0;
        reg_address    = '0;
        reg_write_data = '0;
        out_ready      = 1'b0;
        repeat (4) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);

        check_flag("out_valid", out_valid, 1'b0);
        check_flag("frame_done", frame_done, 1'b0);
        check_flag("ch_ready", |ch_ready, 1'b0);
        check_flag("trigger_out", |trigger_out, 1'b0);
        expect_reg(ADDR_FRAME_LENGTH, 32'd8, "frame_length");
        expect_reg(ADDR_TRIGGER_SELECT, 32'd0, "trigger_select");
        expect_reg(ADDR_TRIGGER_POSITION, 32'd0, "trigger_position");
        expect_reg(ADDR_SOFT_TRIGGER, 32'd0, "soft_trigger");
        expect_reg(ADDR_CAPTURE_ACK, 32'd0, "capture_status");
        expect_reg(3'd6, 32'd0, "unmapped");
        write_reg(ADDR_FRAME_LENGTH, 32'h1234_00a5);
        write_reg(ADDR_TRIGGER_SELECT, 32'hffff_ffff);
        write_reg(ADDR_TRIGGER_POSITION, 32'h0001_0077);
        expect_reg(ADDR_FRAME_LENGTH, 32'h0000_00a5, "frame_length");
        expect_reg(ADDR_TRIGGER_SELECT, 32'h0000_0003, "trigger_select");
        expect_reg(ADDR_TRIGGER_POSITION, 32'h0000_0077, "trigger_position");
        write_reg(ADDR_FRAME_LENGTH, 32'd8);
        write_reg(ADDR_TRIGGER_SELECT, 32'd0);
        write_reg(ADDR_TRIGGER_POSITION, 32'd0);

        // Whole frames only, so the frame position is back at 0 after each phase
        send_words(96, 1'b1, 1'b0);
        wait_drained();
        write_reg(ADDR_FRAME_LENGTH, 32'd5);
        send_words(100, 1'b1, 1'b0);
        wait_drained();
        send_words(200, 1'b1, 1'b1);
        wait_drained();

        write_reg(ADDR_TRIGGER_SELECT, 32'd2);
        write_reg(ADDR_TRIGGER_POSITION, 32'd3);
        done_before    = done_count;
        trigger_before = trigger_count;
        write_reg(ADDR_SOFT_TRIGGER, 32'd1);
        send_words(5, 1'b1, 1'b0);
        wait_drained();
        if (trigger_count != trigger_before + 1) begin
            $display("Expected one trigger pulse but saw %0d", trigger_count - trigger_before);
            report_failure();
        end
        for (int b = 0; b < N_TRIGGERS; b++) begin
            check_flag($sformatf("trigger_out[%0d]", b), trigger_bits[b], b == 2);
        end
        if (done_count != done_before + 1 || done_at_trigger != done_before) begin
            $display("Expected one frame_done after the trigger pulse but saw %0d",
                     done_count - done_before);
            report_failure();
        end

        // Captured frame is held, so these words must vanish
        expect_reg(ADDR_CAPTURE_ACK, 32'd1, "capture_status");
        send_words(12, 1'b0, 1'b0);
        expect_reg(ADDR_CAPTURE_ACK, 32'd1, "capture_status");
        check_flag("out_valid", out_valid, 1'b0);
        write_reg(ADDR_CAPTURE_ACK, 32'd1);
        expect_reg(ADDR_CAPTURE_ACK, 32'd0, "capture_status");
        send_words(5, 1'b1, 1'b0);
        wait_drained();
        if (done_count != done_before + 2 || trigger_count != trigger_before + 1) begin
            $display("Wrong pulse count after the acknowledge: %0d frame_done, %0d triggers",
                     done_count - done_before, trigger_count - trigger_before);
            report_failure();
        end

        if (pending_samples() == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("%0d samples never reached the output", pending_samples());
            report_failure();
        end
    end

endmodule

//--- scope_capture.f
logic/scope_pkg.sv
logic/scope_regs_pkg.sv
logic/scope_registers.sv
logic/channel_combiner.sv
logic/trigger_hub.sv
logic/frame_marker.sv
logic/capture_fifo.sv
logic/scope_capture.sv
test/scope_capture_asserts.sv
test/scope_capture_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the capture path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module scope_capture_tb -f scope_capture.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vscope_capture_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
echo "Simulation finished without errors"
exit 0
